// File: tests/walk_input.txt
// count of page-table words, then one "address data" pair per line
// then count of requests, then one row each: batch requester vaddr rootPpn nacks loads
//   load1 load2 superPage pageFault ppn rwx globl user (results in this order)
0000000A
00010004 00004401
00010008 005000CB
0001000C 005004CB
00010010 002AF0FE
00010014 20000001
0001100C 048D1477
00011014 001DDCBF
00011018 002220F5
0001101C 002664FD
00011020 002AA8F1
00000009
// two-level walk to a leaf, write masked by clear d
0 0 00403000 00010 0 2 00010004 0001100C 0 0 012345 4 1 1
// aligned superpage behind two NACKs
1 1 00800000 00010 2 1 00010008 00000000 1 0 001400 5 0 0
// held together: misaligned superpage, invalid PTE, a clear
2 2 00C00000 00010 0 1 0001000C 00000000 1 1 001401 0 0 0
2 1 01000000 00010 1 1 00010010 00000000 1 1 000ABC 0 0 0
2 0 00405000 00010 0 2 00010004 00011014 0 1 000777 0 0 0
// reserved rwx codes 010, 110 and 000
3 0 00406000 00010 0 2 00010004 00011018 0 1 000888 0 0 0
4 1 00407000 00010 1 2 00010004 0001101C 0 1 000999 0 0 0
5 2 00408000 00010 0 2 00010004 00011020 0 1 000AAA 0 0 0
// pointer to an illegal level-0 address ends as a faulting leaf
5 0 01400000 00010 2 1 00010014 00000000 1 1 080000 0 0 0

// File: sim.f
+incdir+include
logic/mem_pkg.sv
logic/mmu_pkg.sv
logic/walkReqArbiter.sv
logic/pteDecoder.sv
logic/retryTimer.sv
logic/walkController.sv
logic/pageWalkUnit.sv
tests/pageWalkUnit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the page walker testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module pageWalkUnit_tb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

// File: tests/pageWalkUnit_tb.sv
`timescale 1ns/1ps

`include "walk_consts.svh"

module pageWalkUnit_tb
    import mem_pkg::*;
    import mmu_pkg::*;
;

    localparam int NUM_RQS = 3;
    // words per request row of the input file
    localparam int ROW = 14;
    localparam int LATENCY = 3;
    localparam int STALL_ALLOWANCE = 16;

    logic clk;
    logic rst;
    WalkReq rqs [NUM_RQS-1:0];
    logic ldStall;
    LoadAck ldAck [`PW_NUM_AGUS-1:0];
    LoadResult ldRes [`PW_NUM_AGUS-1:0];
    PwLoadReq ldReq;
    WalkRes res;

    logic [31:0] vec [0:255];
    int numMem;
    int numReq;
    int reqBase;
    int cyc;
    int limit;
    int errorCount;
    int cur;
    int loadIdx;
    int nacksLeft;
    int ackAt;
    int resAt;
    int retryAt;
    logic [31:0] resData;
    logic prevHeld;
    logic [31:0] heldAddr;
    logic [31:0] lfsr;

    pageWalkUnit #(
        .NUM_RQS(NUM_RQS)
    ) pageWalkUnit_i (
        .clk(clk),
        .rst(rst),
        .rqs(rqs),
        .ldStall(ldStall),
        .ldAck(ldAck),
        .ldRes(ldRes),
        .ldReq(ldReq),
        .res(res)
    );

    always begin
        #20 clk = ~clk;
    end

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic takeBit(output logic b);
        b = lfsr[0];
        lfsr = galoisStep(lfsr);
    endtask

    // word k of request row r
    function automatic logic [31:0] field(input int r, input int k);
        return vec[reqBase + r * ROW + k];
    endfunction

    task automatic stopRun();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkRes(input WalkRes got, input WalkRes exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic checkLoad(input PwLoadReq got, input PwLoadReq exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            stopRun();
        end
    endtask

    function automatic WalkRes expectedRes(input int r);
        WalkRes e;
        logic [31:0] rq;
        logic [31:0] va;
        logic [31:0] ppn;
        logic [31:0] rwx;
        e = '0;
        rq = field(r, 1);
        va = field(r, 2);
        ppn = field(r, 10);
        rwx = field(r, 11);
        e.valid = 1'b1;
        e.rqId = rq[1:0];
        e.superPage = field(r, 8) != 32'd0;
        e.pageFault = field(r, 9) != 32'd0;
        e.ppn = ppn[21:0];
        e.vpn = va[31:12];
        e.rwx = rwx[2:0];
        e.globl = field(r, 12) != 32'd0;
        e.user = field(r, 13) != 32'd0;
        return e;
    endfunction

    task automatic readMem(input logic [31:0] addr, output logic [31:0] data);
        logic found;
        found = 1'b0;
        data = 32'd0;
        for (int i = 0; i < numMem; i++) begin
            if (vec[1 + 2 * i] == addr) begin
                data = vec[2 + 2 * i];
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("load from an address with no page-table word: %h", addr);
            stopRun();
        end
    endtask

    // one clock edge of the load/store unit model and the result monitor
    task automatic stepCycle();
        PwLoadReq expLoad;
        logic b;
        logic port;
        int nLoads;
        cyc++;
        if (cyc > limit) begin
            $display("timeout: walks not finished after %0d cycles", limit);
            stopRun();
        end
        nLoads = (cur < numReq) ? int'(field(cur, 5)) : 0;

        // a stalled load must stay put
        if (prevHeld) begin
            expLoad.valid = 1'b1;
            expLoad.addr = heldAddr;
            checkLoad(ldReq, expLoad, "stalled load");
        end
        // the walker reports busy for as long as a load is out
        if (ldReq.valid && !res.busy) begin
            errorCount++;
            $display("mismatch at %0t ns: busy low while a walk load is pending", $time);
            stopRun();
        end
        if (retryAt >= 0) begin
            if (ldReq.valid) begin
                if (cyc != retryAt) begin
                    errorCount++;
                    $display("mismatch at %0t ns: retry at cycle %0d expected %0d",
                             $time, cyc, retryAt);
                    stopRun();
                end
                retryAt = -1;
            end else if (cyc > retryAt) begin
                $display("rejected load was not issued again");
                stopRun();
            end
        end

        if (ldReq.valid && !ldStall) begin
            if (cur >= numReq || loadIdx >= nLoads) begin
                $display("load issued that no walk should make: %h", ldReq.addr);
                stopRun();
            end
            expLoad.valid = 1'b1;
            expLoad.addr = field(cur, 6 + loadIdx);
            checkLoad(ldReq, expLoad, "load address");
            if (nacksLeft > 0) begin
                nacksLeft--;
                ackAt = cyc + 1;
            end else begin
                resAt = cyc + LATENCY;
                readMem(ldReq.addr, resData);
            end
        end
        prevHeld = ldReq.valid && ldStall;
        heldAddr = ldReq.addr;

        for (int p = 0; p < `PW_NUM_AGUS; p++) begin
            ldAck[p] <= '0;
            ldRes[p] <= '0;
        end
        if (cyc == ackAt) begin
            takeBit(port);
            ldAck[port] <= '{valid: 1'b1, external: 1'b1, fail: 1'b1};
            // the ack is sampled on the next edge and the load returns DELAY edges after it
            retryAt = cyc + 1 + int'(`PW_RETRY_DELAY);
            ackAt = -1;
        end
        if (cyc == resAt) begin
            takeBit(port);
            ldRes[port] <= '{valid: 1'b1, doNotCommit: 1'b1, tag: 7'd0, data: resData};
            loadIdx++;
            nacksLeft = int'(field(cur, 4));
            resAt = -1;
        end

        if (res.valid) begin
            if (cur >= numReq) begin
                $display("walk result with no request left");
                stopRun();
            end
            checkRes(res, expectedRes(cur), "walk result");
            if (loadIdx != nLoads) begin
                $display("walk finished after %0d loads instead of %0d", loadIdx, nLoads);
                stopRun();
            end
            rqs[res.rqId].valid <= 1'b0;
            cur++;
            loadIdx = 0;
            nacksLeft = (cur < numReq) ? int'(field(cur, 4)) : 0;
        end

        takeBit(b);
        ldStall <= b;
    endtask

    initial begin
        int idx;
        int last;
        int maxNack;
        logic [31:0] rq;
        logic [31:0] va;
        logic [31:0] root;
        clk = 1'b0;
        rst = 1'b1;
        ldStall = 1'b0;
        for (int i = 0; i < NUM_RQS; i++) begin
            rqs[i] = '0;
        end
        for (int p = 0; p < `PW_NUM_AGUS; p++) begin
            ldAck[p] = '0;
            ldRes[p] = '0;
        end
        lfsr = 32'h9e7a_e2cd;
        cyc = 0;
        errorCount = 0;
        cur = 0;
        loadIdx = 0;
        ackAt = -1;
        resAt = -1;
        retryAt = -1;
        prevHeld = 1'b0;
        heldAddr = 32'd0;
        resData = 32'd0;

        $readmemh("tests/walk_input.txt", vec);
        numMem = int'(vec[0]);
        numReq = int'(vec[1 + 2 * numMem]);
        reqBase = 2 + 2 * numMem;
        maxNack = 0;
        for (int r = 0; r < numReq; r++) begin
            if (int'(field(r, 4)) > maxNack) begin
                maxNack = int'(field(r, 4));
            end
        end
        limit = numReq * 2 * (LATENCY + STALL_ALLOWANCE
                + maxNack * (int'(`PW_RETRY_DELAY) + 2)) + 40 * numReq + 50;
        nacksLeft = (numReq > 0) ? int'(field(0, 4)) : 0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checkLoad(ldReq, '0, "load after reset");
        checkRes(res, '0, "result after reset");

        idx = 0;
        while (idx < numReq) begin
            // every request of a batch is raised on the same edge
            last = idx;
            while (last < numReq && field(last, 0) == field(idx, 0)) begin
                rq = field(last, 1);
                va = field(last, 2);
                root = field(last, 3);
                rqs[rq[1:0]] <= '{valid: 1'b1, addr: va, rootPpn: root[19:0]};
                last++;
            end
            while (cur < last) begin
                @(posedge clk);
                stepCycle();
            end
            idx = last;
        end

        repeat (4) begin
            @(posedge clk);
            stepCycle();
        end
        if (errorCount == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stopRun();
        end
    end

endmodule

// File: logic/pageWalkUnit.sv
`timescale 1ns/1ps

`include "walk_consts.svh"

module pageWalkUnit
    import mem_pkg::*;
    import mmu_pkg::*;
#(
    parameter int NUM_RQS = 3
) (
    input  logic clk,
    input  logic rst,
    input  WalkReq rqs [NUM_RQS-1:0],
    input  logic ldStall,
    input  LoadAck ldAck [`PW_NUM_AGUS-1:0],
    input  LoadResult ldRes [`PW_NUM_AGUS-1:0],
    output PwLoadReq ldReq,
    output WalkRes res
);

    WalkReq sel;
    logic [1:0] selId;
    logic anyValid;
    logic resValid;
    PteInfo info;
    logic retryStart;
    logic retryDone;
    logic level;
    logic [31:0] vaddr;

    walkReqArbiter #(
        .NUM_RQS(NUM_RQS)
    ) arbiter (
        .rqs(rqs),
        .sel(sel),
        .selId(selId),
        .anyValid(anyValid)
    );

    walkController controller (
        .clk(clk),
        .rst(rst),
        .sel(sel),
        .selId(selId),
        .anyValid(anyValid),
        .ldStall(ldStall),
        .ldAck(ldAck),
        .resValid(resValid),
        .info(info),
        .retryDone(retryDone),
        .ldReq(ldReq),
        .res(res),
        .retryStart(retryStart),
        .level(level),
        .vaddr(vaddr)
    );

    retryTimer timer (
        .clk(clk),
        .rst(rst),
        .start(retryStart),
        .done(retryDone)
    );

    pteDecoder decoder (
        .ldRes(ldRes),
        .level(level),
        .vaddr(vaddr),
        .resValid(resValid),
        .info(info)
    );

endmodule

// File: logic/walkController.sv
`timescale 1ns/1ps

`include "walk_consts.svh"

module walkController
    import mem_pkg::*;
    import mmu_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  WalkReq sel,
    input  logic [1:0] selId,
    input  logic anyValid,
    input  logic ldStall,
    input  LoadAck ldAck [`PW_NUM_AGUS-1:0],
    input  logic resValid,
    input  PteInfo info,
    input  logic retryDone,
    output PwLoadReq ldReq,
    output WalkRes res,
    output logic retryStart,
    output logic level,
    output logic [31:0] vaddr
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_LOAD,
        BACKOFF
    } WalkState;

    WalkState state;
    logic nack;

    always_comb begin
        nack = 1'b0;
        for (int i = 0; i < `PW_NUM_AGUS; i++) begin
            if (ldAck[i].valid && ldAck[i].external && ldAck[i].fail) begin
                nack = 1'b1;
            end
        end
    end

    // a NACK only matters once our load has left the strobe
    assign retryStart = (state == WAIT_LOAD) && !ldReq.valid && !resValid && nack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            ldReq <= '0;
            res <= '0;
            level <= 1'b0;
            vaddr <= 32'd0;
        end else begin
            res.valid <= 1'b0;

            case (state)
                IDLE: begin
                    // skip the result cycle, the finished requester still holds valid
                    if (anyValid && !res.valid) begin
                        state <= WAIT_LOAD;
                        level <= 1'b1;
                        vaddr <= sel.addr;
                        ldReq.valid <= 1'b1;
                        ldReq.addr <= {sel.rootPpn, sel.addr[31:22], 2'b00};
                        res <= '0;
                        res.rqId <= selId;
                        res.busy <= 1'b1;
                    end
                end

                WAIT_LOAD: begin
                    if (ldReq.valid) begin
                        // strobe stays up until the load unit takes it
                        if (!ldStall) begin
                            ldReq.valid <= 1'b0;
                        end
                    end else if (resValid) begin
                        if (info.isPointer) begin
                            level <= 1'b0;
                            ldReq.valid <= 1'b1;
                            ldReq.addr <= info.nextAddr;
                        end else begin
                            state <= IDLE;
                            res.valid <= 1'b1;
                            res.busy <= 1'b0;
                            res.superPage <= info.superPage;
                            res.pageFault <= info.pageFault;
                            res.ppn <= info.ppn;
                            res.vpn <= vaddr[31:12];
                            res.rwx <= info.rwx;
                            res.globl <= info.globl;
                            res.user <= info.user;
                        end
                    end else if (nack) begin
                        state <= BACKOFF;
                    end
                end

                BACKOFF: begin
                    // address is still in ldReq, only the strobe comes back
                    if (retryDone) begin
                        state <= WAIT_LOAD;
                        ldReq.valid <= 1'b1;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/retryTimer.sv
`timescale 1ns/1ps

`include "walk_consts.svh"

module retryTimer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    logic [2:0] count;

    // the acknowledge cycle itself is the first back-off cycle,
    // so the load goes out again PW_RETRY_DELAY cycles after the NACK
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= 3'd0;
        end else if (start) begin
            count <= `PW_RETRY_DELAY - 3'd1;
        end else if (count != 3'd0) begin
            count <= count - 3'd1;
        end
    end

    // last back-off cycle, the count hits zero on the next edge
    assign done = (count == 3'd1);

endmodule

// File: logic/pteDecoder.sv
`timescale 1ns/1ps

`include "walk_consts.svh"

module pteDecoder
    import mem_pkg::*;
    import mmu_pkg::*;
(
    input  LoadResult ldRes [`PW_NUM_AGUS-1:0],
    input  logic level,
    input  logic [31:0] vaddr,
    output logic resValid,
    output PteInfo info
);

    LoadResult walkLd;
    Pte pte;
    logic [31:0] nextAddr;
    logic [2:0] xwr;
    logic fault;

    // only one walk load is in flight, so at most one port carries our data
    always_comb begin
        walkLd = '0;
        for (int i = 0; i < `PW_NUM_AGUS; i++) begin
            if (ldRes[i].valid && ldRes[i].doNotCommit && ldRes[i].tag == 7'd0) begin
                walkLd = ldRes[i];
            end
        end
    end

    assign resValid = walkLd.valid;
    assign pte = walkLd.data;

    // level-0 address: PTE bits 29:10 followed by VPN0
    assign nextAddr = {pte.ptr.ppn[19:0], vaddr[21:12], 2'b00};
    assign xwr = {pte.leaf.x, pte.leaf.w, pte.leaf.r};

    always_comb begin
        fault = !pte.leaf.v || !pte.leaf.a;
        // no permission, write-only and write-execute are reserved encodings
        case (xwr)
            3'b000, 3'b010, 3'b110: fault = 1'b1;
            default: ;
        endcase
        // a superpage must be aligned to 4 MiB
        if (level && pte.leaf.ppn0 != 10'd0) begin
            fault = 1'b1;
        end
    end

    always_comb begin
        info = '0;
        info.isPointer = {pte.ptr.x, pte.ptr.w, pte.ptr.r, pte.ptr.v} == 4'b0001
                         && pte.ptr.ppn[21:20] == 2'b00
                         && level
                         && `PW_IS_LEGAL_ADDR(nextAddr);
        info.nextAddr = nextAddr;
        info.superPage = level;
        info.pageFault = fault;
        info.ppn = {pte.leaf.ppn1, pte.leaf.ppn0};
        if (!fault) begin
            // write is granted only once the page is already dirty
            info.rwx = {pte.leaf.r, pte.leaf.w && pte.leaf.d, pte.leaf.x};
            info.globl = pte.leaf.g;
            info.user = pte.leaf.u;
        end
    end

endmodule

// File: logic/walkReqArbiter.sv
`timescale 1ns/1ps

module walkReqArbiter
    import mmu_pkg::*;
#(
    parameter int NUM_RQS = 3
) (
    input  WalkReq rqs [NUM_RQS-1:0],
    output WalkReq sel,
    output logic [1:0] selId,
    output logic anyValid
);

    always_comb begin
        sel = '0;
        selId = 2'd0;
        anyValid = 1'b0;
        // later indices overwrite earlier ones, so the highest valid index wins
        for (int i = 0; i < NUM_RQS; i++) begin
            if (rqs[i].valid) begin
                sel = rqs[i];
                selId = i[1:0];
                anyValid = 1'b1;
            end
        end
    end

endmodule

// File: logic/mmu_pkg.sv
package mmu_pkg;

    // translation request, held as a level by a TLB
    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [19:0] rootPpn;
    } WalkReq;

    // walk result, valid is a single-cycle pulse
    typedef struct packed {
        logic valid;
        logic busy;
        logic [1:0] rqId;
        logic superPage;
        logic pageFault;
        logic [21:0] ppn;
        logic [19:0] vpn;
        logic [2:0] rwx;
        logic globl;
        logic user;
    } WalkRes;

    // pointer view of a Sv32 PTE
    typedef struct packed {
        logic [21:0] ppn;
        logic [1:0] rsw;
        logic [3:0] unused;
        logic x;
        logic w;
        logic r;
        logic v;
    } PtePtr;

    // leaf view of a Sv32 PTE
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0] ppn0;
        logic [1:0] rsw;
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } PteLeaf;

    typedef union packed {
        PtePtr ptr;
        PteLeaf leaf;
    } Pte;

    // decoded PTE as seen by the walk controller
    typedef struct packed {
        logic isPointer;
        logic [31:0] nextAddr;
        logic superPage;
        logic pageFault;
        logic [21:0] ppn;
        logic [2:0] rwx;
        logic globl;
        logic user;
    } PteInfo;

endpackage

// File: logic/mem_pkg.sv
package mem_pkg;

    // walk load sent to the load/store unit
    typedef struct packed {
        logic valid;
        logic [31:0] addr;
    } PwLoadReq;

    // per-port acknowledge of an accepted load
    // walker loads are flagged as external, fail means the load was dropped
    typedef struct packed {
        logic valid;
        logic external;
        logic fail;
    } LoadAck;

    // load data returned on one result port
    // walker data comes back with doNotCommit set and tag zero
    typedef struct packed {
        logic valid;
        logic doNotCommit;
        logic [6:0] tag;
        logic [31:0] data;
    } LoadResult;

endpackage

// File: include/walk_consts.svh
`ifndef WALK_CONSTS_SVH
`define WALK_CONSTS_SVH

// load-result and acknowledge ports of the load/store unit
`define PW_NUM_AGUS 2

// back-off cycles between a rejected walk load and its re-issue
`define PW_RETRY_DELAY 3'd4

// first physical address outside of the memory map
`define PW_PHYS_TOP 32'h8000_0000

// true when a physical address lies inside the memory map
`define PW_IS_LEGAL_ADDR(addr) ((addr) < `PW_PHYS_TOP)

`endif
